// ==== cache_pkg.sv ====
// Fixed geometry of 256 direct-mapped lines of four 32-bit words; only word-aligned offsets
package cache_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES      = 256;
    localparam int LINE_W         = 128;
    localparam int WSEL_W         = $clog2(WORDS_PER_LINE);  // Word select inside a line

    localparam logic [1:0] MESI_M = 2'b00;
    localparam logic [1:0] MESI_E = 2'b01;
    localparam logic [1:0] MESI_S = 2'b10;
    localparam logic [1:0] MESI_I = 2'b11;

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_LOOKUP = 3'd1;  // Core tag compare
    localparam logic [2:0] ST_SNOOP  = 3'd2;
    localparam logic [2:0] ST_WB     = 3'd3;  // Victim write-back
    localparam logic [2:0] ST_FILL   = 3'd4;

    // Same 128 bits seen flat for bus transfers or as words for select and merge
    typedef union packed {
        logic [LINE_W-1:0]                     flat;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } cache_line_u;

endpackage

// ==== line_port_if.sv ====
// Read side is combinational at index; line_wr and state_wr must never be high together
`timescale 1ns/1ns
interface line_port_if
    import cache_pkg::*;
();

    logic [INDEX_W-1:0] index;

    logic               line_wr;   // Tag, data and state
    logic               state_wr;  // State only
    logic [TAG_W-1:0]   wr_tag;
    cache_line_u        wr_line;
    logic [1:0]         wr_state;  // Shared by both write kinds

    logic [TAG_W-1:0]   rd_tag;
    cache_line_u        rd_line;
    logic [1:0]         rd_state;

    modport ctrl (
        output index, line_wr, state_wr, wr_tag, wr_line, wr_state,
        input  rd_tag, rd_line, rd_state
    );

    modport store (
        input  index, line_wr, state_wr, wr_tag, wr_line, wr_state,
        output rd_tag, rd_line, rd_state
    );

endinterface

// ==== line_store.sv ====
// Reset clears only the MESI states; tag and data contents are undefined until a fill
`timescale 1ns/1ns
module line_store
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    line_port_if.store port
);

    logic [TAG_W-1:0] tag_mem   [NUM_LINES];
    cache_line_u      data_mem  [NUM_LINES];
    logic [1:0]       state_mem [NUM_LINES];

    // Asynchronous read at the current index
    assign port.rd_tag   = tag_mem[port.index];
    assign port.rd_line  = data_mem[port.index];
    assign port.rd_state = state_mem[port.index];

    always_ff @(posedge clk) begin
        if (port.line_wr) begin
            tag_mem[port.index]  <= port.wr_tag;
            data_mem[port.index] <= port.wr_line;
        end
    end

    // The valid bit is just state != I, so this array alone decides residency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state_mem[i] <= MESI_I;
            end
        end else if (port.line_wr || port.state_wr) begin
            state_mem[port.index] <= port.wr_state;
        end
    end

    // Controller must never request both write kinds in one cycle
    a_one_write_kind: assert property (
        @(posedge clk) disable iff (rst) !(port.line_wr && port.state_wr)
    );

endmodule

// ==== cache_ctrl.sv ====
// One request at a time; snoops only taken while idle; a Shared write hit upgrades silently
`timescale 1ns/1ns
module cache_ctrl
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              core_rd,
    input  logic              core_wr,
    input  logic [ADDR_W-1:0] core_addr,
    input  logic [WORD_W-1:0] core_wdata,
    output logic [WORD_W-1:0] core_rdata,
    output logic              core_done,
    output logic              core_hit,
    output logic              busy,
    input  logic              snoop_req,
    input  logic [ADDR_W-1:0] snoop_addr,
    input  logic [1:0]        snoop_state,
    output logic              snoop_done,
    output logic              snoop_hit,
    output logic [LINE_W-1:0] snoop_data,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [LINE_W-1:0] mem_wdata,
    input  logic [LINE_W-1:0] mem_rdata,
    input  logic              mem_ready,
    input  logic [1:0]        mem_fill_state,
    line_port_if.ctrl         port
);

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    logic              missed;         // Current core request went through a fill

    logic [ADDR_W-1:0] req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic              req_wr;
    logic [1:0]        req_snp_state;

    logic [TAG_W-1:0]  req_tag;
    logic [WSEL_W-1:0] word_sel;
    logic              tag_hit;
    logic              accept_snoop;
    logic              accept_core;
    logic              fill_done;
    cache_line_u       merged;

    assign req_tag    = req_addr[ADDR_W-1 -: TAG_W];
    assign word_sel   = req_addr[OFFSET_W-1 -: WSEL_W];
    assign port.index = req_addr[OFFSET_W +: INDEX_W];

    assign tag_hit = (port.rd_state != MESI_I) && (port.rd_tag == req_tag);

    // Snoop has priority when both arrive together
    assign accept_snoop = (state == ST_IDLE) && snoop_req;
    assign accept_core  = (state == ST_IDLE) && !snoop_req && (core_rd || core_wr);
    assign fill_done    = (state == ST_FILL) && mem_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            missed <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept_core) begin
                missed <= 1'b0;
            end else if (fill_done) begin
                missed <= 1'b1;
            end
        end
    end

    // Request payload, captured once at acceptance
    always_ff @(posedge clk) begin
        if (accept_snoop) begin
            req_addr      <= snoop_addr;
            req_snp_state <= snoop_state;
        end else if (accept_core) begin
            req_addr  <= core_addr;
            req_wdata <= core_wdata;
            req_wr    <= core_wr;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept_snoop) begin
                    state_nxt = ST_SNOOP;
                end else if (accept_core) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (tag_hit) begin
                    state_nxt = ST_IDLE;
                end else if (port.rd_state == MESI_M) begin
                    state_nxt = ST_WB;  // Dirty victim goes out first
                end else begin
                    state_nxt = ST_FILL;
                end
            end
            ST_SNOOP: state_nxt = ST_IDLE;
            ST_WB: begin
                if (mem_ready) begin
                    state_nxt = ST_FILL;
                end
            end
            ST_FILL: begin
                if (mem_ready) begin
                    state_nxt = ST_LOOKUP;  // Replay, which now hits
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // Write data lands in its word slot, rest of the line untouched
    always_comb begin
        merged = port.rd_line;
        merged.words[word_sel] = req_wdata;
    end

    always_comb begin
        port.line_wr  = 1'b0;
        port.state_wr = 1'b0;
        port.wr_tag   = req_tag;
        port.wr_line  = merged;
        port.wr_state = MESI_M;
        if ((state == ST_LOOKUP) && tag_hit && req_wr) begin
            port.line_wr = 1'b1;  // Write hit or replayed write, always to M
        end else if (fill_done) begin
            port.line_wr  = 1'b1;
            port.wr_line  = cache_line_u'(mem_rdata);
            port.wr_state = mem_fill_state;
        end else if ((state == ST_SNOOP) && tag_hit) begin
            port.state_wr = 1'b1;
            port.wr_state = req_snp_state;
        end
    end

    assign core_done  = (state == ST_LOOKUP) && tag_hit;
    assign core_hit   = core_done && !missed;
    assign core_rdata = port.rd_line.words[word_sel];

    assign snoop_done = (state == ST_SNOOP);
    assign snoop_hit  = snoop_done && tag_hit;
    assign snoop_data = port.rd_line.flat;

    assign busy = (state != ST_IDLE);

    // Victim address uses the stored tag; index stays fixed for the whole miss
    assign mem_wr    = (state == ST_WB);
    assign mem_rd    = (state == ST_FILL);
    assign mem_addr  = {(state == ST_WB) ? port.rd_tag : req_tag, port.index, OFFSET_W'(0)};
    assign mem_wdata = port.rd_line.flat;

    // A hit pulse only ever comes one cycle after acceptance
    a_hit_latency: assert property (
        @(posedge clk) disable iff (rst) core_hit |-> $past(accept_core)
    );

    // Replayed lookup must find the line the fill just installed
    a_replay_hits: assert property (
        @(posedge clk) disable iff (rst) fill_done |=> tag_hit
    );

    // Address must hold while the next level stalls
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_rd || mem_wr) && !mem_ready |=> $stable(mem_addr)
    );

endmodule

// ==== l1_cache_top.sv ====
// Requests are levels held until their done pulse; memory transfers are whole 128-bit lines
`timescale 1ns/1ns
module l1_cache_top
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              core_rd,
    input  logic              core_wr,
    input  logic [ADDR_W-1:0] core_addr,
    input  logic [WORD_W-1:0] core_wdata,
    output logic [WORD_W-1:0] core_rdata,
    output logic              core_done,
    output logic              core_hit,
    output logic              busy,
    input  logic              snoop_req,
    input  logic [ADDR_W-1:0] snoop_addr,
    input  logic [1:0]        snoop_state,
    output logic              snoop_done,
    output logic              snoop_hit,
    output logic [LINE_W-1:0] snoop_data,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [LINE_W-1:0] mem_wdata,
    input  logic [LINE_W-1:0] mem_rdata,
    input  logic              mem_ready,
    input  logic [1:0]        mem_fill_state
);

    line_port_if lp ();

    cache_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .core_rd        (core_rd),
        .core_wr        (core_wr),
        .core_addr      (core_addr),
        .core_wdata     (core_wdata),
        .core_rdata     (core_rdata),
        .core_done      (core_done),
        .core_hit       (core_hit),
        .busy           (busy),
        .snoop_req      (snoop_req),
        .snoop_addr     (snoop_addr),
        .snoop_state    (snoop_state),
        .snoop_done     (snoop_done),
        .snoop_hit      (snoop_hit),
        .snoop_data     (snoop_data),
        .mem_rd         (mem_rd),
        .mem_wr         (mem_wr),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .mem_fill_state (mem_fill_state),
        .port           (lp.ctrl)
    );

    line_store i_store (
        .clk  (clk),
        .rst  (rst),
        .port (lp.store)
    );

endmodule

// ==== tb_l1_cache.sv ====
// Reads cache_input.txt from the working directory; the next level answers after 0 to 3 random cycles
`timescale 1ns/1ns
module tb_l1_cache
    import cache_pkg::*;
();

    localparam logic [WORD_W-1:0] MEM_PATTERN = 32'hF0F0_0000;

    logic              clk;
    logic              rst = 1'b1;
    logic              core_rd = 1'b0;
    logic              core_wr = 1'b0;
    logic [ADDR_W-1:0] core_addr = '0;
    logic [WORD_W-1:0] core_wdata = '0;
    logic [WORD_W-1:0] core_rdata;
    logic              core_done;
    logic              core_hit;
    logic              busy;
    logic              snoop_req = 1'b0;
    logic [ADDR_W-1:0] snoop_addr = '0;
    logic [1:0]        snoop_state = MESI_I;
    logic              snoop_done;
    logic              snoop_hit;
    logic [LINE_W-1:0] snoop_data;
    logic              mem_rd;
    logic              mem_wr;
    logic [ADDR_W-1:0] mem_addr;
    logic [LINE_W-1:0] mem_wdata;
    logic [LINE_W-1:0] mem_rdata = '0;
    logic              mem_ready = 1'b0;
    logic [1:0]        mem_fill_state = MESI_E;

    logic [7:0]        op_q   [$];  // Operation letters
    logic [ADDR_W-1:0] addr_q [$];
    logic [WORD_W-1:0] data_q [$];  // Write word or snoop state
    logic              hit_q  [$];
    logic [WORD_W-1:0] exp_q  [$];
    logic [1:0]        fill_q [$];

    logic [LINE_W-1:0] mem_lines [logic [ADDR_W-1:0]];  // Written-back lines only
    logic              mem_active = 1'b0;
    int                wait_left = 0;
    integer            seed = 34;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int max_cycles = 1000;

    l1_cache_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Unwritten lines follow the address rule word by word
    function automatic logic [LINE_W-1:0] memory_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_W +: WORD_W] = (base + ADDR_W'(w * 4)) ^ MEM_PATTERN;
        end
        return line;
    endfunction

    // Next-level model, one transfer at a time
    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            mem_active = 1'b0;
        end else if (mem_ready) begin
            if (mem_wr) begin
                mem_lines[mem_addr] = mem_wdata;  // Keep the write-back
            end
            mem_ready <= 1'b0;
            mem_active = 1'b0;
        end else if (mem_rd || mem_wr) begin
            if (!mem_active) begin
                mem_active = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= memory_line(mem_addr);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run did not end within %0d cycles", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic load_stimulus();
        int          fd;
        int          count;
        string       text;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] hit;
        logic [31:0] exp_word;
        logic [31:0] fill;
        fd = $fopen("cache_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open cache_input.txt");
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 0 && text.getc(0) != "#") begin
                count = $sscanf(text, "%c %h %h %h %h %h", op, addr, data, hit, exp_word, fill);
                if (count == 6) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    hit_q.push_back(hit[0]);
                    exp_q.push_back(exp_word);
                    fill_q.push_back(fill[1:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int n);
        logic [7:0]        op;
        logic              saw_snoop;
        logic              busy_ok;
        logic              got_hit;
        logic [WORD_W-1:0] got_word;
        int                cyc;
        int                errors_before;
        op = op_q[n];
        errors_before = errors;
        @(posedge clk);
        mem_fill_state <= fill_q[n];
        if (op == "S") begin
            snoop_req   <= 1'b1;
            snoop_addr  <= addr_q[n];
            snoop_state <= data_q[n][1:0];
        end else begin
            core_rd    <= (op == "R");
            core_wr    <= (op == "W");
            core_addr  <= addr_q[n];
            core_wdata <= data_q[n];
        end
        cyc = 0;
        busy_ok = 1'b1;
        do begin
            @(negedge clk);
            if (cyc > 0 && !busy) begin
                busy_ok = 1'b0;  // First half cycle is still idle
            end
            cyc++;
        end while (!core_done && !snoop_done);
        saw_snoop = snoop_done;
        got_hit   = (op == "S") ? snoop_hit : core_hit;
        got_word  = (op == "S") ? snoop_data[WORD_W-1:0] : core_rdata;
        @(posedge clk);
        core_rd   <= 1'b0;
        core_wr   <= 1'b0;
        snoop_req <= 1'b0;
        if (saw_snoop != (op == "S")) begin
            $display("Test %0d: the done pulse came from the wrong side", n);
            errors++;
        end
        if (!busy_ok) begin
            $display("Test %0d: busy went low before the done pulse", n);
            errors++;
        end
        if (got_hit !== hit_q[n]) begin
            $display("FAILED at %0t ns: test %0d %c %h hit %0b, expected %0b",
                     $time, n, op, addr_q[n], got_hit, hit_q[n]);
            errors++;
        end
        // Writes return no data, a snoop miss returns nothing useful
        if (op != "W" && (op == "R" || hit_q[n]) && got_word !== exp_q[n]) begin
            $display("FAILED at %0t ns: test %0d %c %h data %h, expected %h",
                     $time, n, op, addr_q[n], got_word, exp_q[n]);
            errors++;
        end
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %0d %c %h passed", n, op, addr_q[n]);
        end else begin
            tests_failed++;
            $display("Test %0d %c %h did not pass", n, op, addr_q[n]);
        end
    endtask

    initial begin
        load_stimulus();
        max_cycles = 20 * op_q.size() + 20;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (core_done || core_hit || snoop_done || snoop_hit || mem_rd || mem_wr || busy) begin
            $display("Outputs were not all low after reset");
            errors++;
        end
        if (op_q.size() == 0) begin
            $display("No operations were read from cache_input.txt");
            errors++;
        end
        for (int n = 0; n < op_q.size(); n++) begin
            run_op(n);
        end
        $display("%0d tests: %0d passed, %0d failed", op_q.size(), tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== cache_input.txt ====
# op addr data hit expect fill; data is the write word or snoop state, expect the read word or word 0
# fill is the MESI state given on a line fill: 0 M, 1 E, 2 S, 3 I
R 00001000 00000000 0 F0F01000 1
R 00001000 00000000 1 F0F01000 1
R 00001008 00000000 1 F0F01008 1
W 00001004 11112222 1 00000000 1
R 00001004 00000000 1 11112222 1
R 0000100C 00000000 1 F0F0100C 1
W 00002040 DEADBEEF 0 00000000 1
R 00002044 00000000 1 F0F02044 1
R 00003040 00000000 0 F0F03040 1
R 00002040 00000000 0 DEADBEEF 1
R 00002044 00000000 1 F0F02044 1
R 00005000 00000000 0 F0F05000 2
R 00001004 00000000 0 11112222 1
S 00001004 00000003 1 F0F01000 1
R 00001004 00000000 0 11112222 1
S 00002040 00000002 1 DEADBEEF 1
R 00002040 00000000 1 DEADBEEF 1
W 00002048 CAFEF00D 1 00000000 1
R 0000204C 00000000 1 F0F0204C 1
S 00007080 00000003 0 00000000 1
S 00006040 00000002 0 00000000 1
R 00007080 00000000 0 F0F07080 1
R 00007084 00000000 1 F0F07084 1
R 00002048 00000000 1 CAFEF00D 1
W 00008400 01234567 0 00000000 0
R 00008400 00000000 1 01234567 0
R 00009400 00000000 0 F0F09400 1
R 00008400 00000000 0 01234567 1

// ==== sim.f ====
cache_pkg.sv
line_port_if.sv
line_store.sv
cache_ctrl.sv
l1_cache_top.sv
tb_l1_cache.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

.PHONY: run clean

run: obj_dir/Vtb_l1_cache cache_input.txt
	./obj_dir/Vtb_l1_cache > sim.log 2>&1 || echo "Something failed" >> sim.log
	cat sim.log
	! grep -q "Something failed" sim.log

obj_dir/Vtb_l1_cache: $(SRCS) sim.f
	verilator --binary --timing --assert --top-module tb_l1_cache -f sim.f

clean:
	rm -rf obj_dir sim.log
